// ==== port_controller_local.f ====
+incdir+tests
rtl/noc_pkg.sv
rtl/round_robin_arbiter.sv
rtl/grant_fifo.sv
rtl/port_controller_local.sv
tests/tb_port_controller_local.sv

// ==== rtl/grant_fifo.sv ====
`default_nettype none

module grant_fifo (
  input  var logic                i_clk,
  input  var logic                i_rst_n,
  input  var logic                i_push,
  input  var noc_pkg::port_mask_t i_data,
  input  var logic                i_pop,
  output var noc_pkg::port_mask_t o_data,
  output var logic                o_full
);

  typedef logic [$clog2(noc_pkg::GRANT_FIFO_DEPTH)-1:0] ptr_t;
  typedef logic [$clog2(noc_pkg::GRANT_FIFO_DEPTH+1)-1:0] count_t;

  noc_pkg::port_mask_t mem [noc_pkg::GRANT_FIFO_DEPTH];
  ptr_t wr_ptr_q;
  ptr_t rd_ptr_q;
  ptr_t rd_ptr_next;
  count_t count_q;
  count_t count_next;
  count_t remaining;
  logic push_en;
  logic pop_en;
  noc_pkg::port_mask_t head_next;

  assign push_en = i_push && !o_full;
  // Pop on an empty FIFO is dropped
  assign pop_en = i_pop && (count_q != '0);

  always_comb begin
    rd_ptr_next = rd_ptr_q;
    if (pop_en) begin
      if (rd_ptr_q == ptr_t'(noc_pkg::GRANT_FIFO_DEPTH - 1)) begin
        rd_ptr_next = '0;
      end else begin
        rd_ptr_next = rd_ptr_q + 1'b1;
      end
    end
    remaining = count_q - count_t'(pop_en);
    count_next = remaining + count_t'(push_en);
  end

  // Head after this edge, zero when nothing is left
  always_comb begin
    if (remaining != '0) begin
      head_next = mem[rd_ptr_next];
    end else if (push_en) begin
      head_next = i_data;
    end else begin
      head_next = '0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (push_en) begin
      mem[wr_ptr_q] <= i_data;
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q <= '0;
      o_data <= '0;
      o_full <= 1'b0;
    end else begin
      if (push_en) begin
        if (wr_ptr_q == ptr_t'(noc_pkg::GRANT_FIFO_DEPTH - 1)) begin
          wr_ptr_q <= '0;
        end else begin
          wr_ptr_q <= wr_ptr_q + 1'b1;
        end
      end
      rd_ptr_q <= rd_ptr_next;
      count_q <= count_next;
      o_data <= head_next;
      o_full <= (count_next == count_t'(noc_pkg::GRANT_FIFO_DEPTH));
    end
  end

  // Grants are blocked upstream while full, so no packet can complete
  a_no_push_full : assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    i_push |-> !o_full
  );

endmodule

`default_nettype wire

// ==== rtl/noc_pkg.sv ====
`default_nettype none

package noc_pkg;

  // Virtual channels carried on every link
  localparam int CHANNELS = 2;

  // Router input ports, local core plus four directions
  localparam int PORTS = 5;

  // Port grant masks buffered per channel at the output switch
  localparam int GRANT_FIFO_DEPTH = 2;

  // One bit per virtual channel
  typedef logic [CHANNELS-1:0] vc_mask_t;

  // One bit per input port, used for switch selection
  typedef logic [PORTS-1:0] port_mask_t;

endpackage

`default_nettype wire

// ==== rtl/port_controller_local.sv ====
`default_nettype none

module port_controller_local (
  input  var logic                                        i_clk,
  input  var logic                                        i_rst_n,
  input  var noc_pkg::vc_mask_t                           i_vc_ready,
  input  var noc_pkg::vc_mask_t [noc_pkg::PORTS-1:0]      i_start_of_packet,
  input  var noc_pkg::vc_mask_t [noc_pkg::PORTS-1:0]      i_end_of_packet,
  input  var noc_pkg::vc_mask_t [noc_pkg::PORTS-1:0]      i_request,
  input  var noc_pkg::vc_mask_t [noc_pkg::PORTS-1:0]      i_free,
  output var noc_pkg::vc_mask_t [noc_pkg::PORTS-1:0]      o_grant,
  output var noc_pkg::port_mask_t [noc_pkg::CHANNELS-1:0] o_output_grant,
  input  var noc_pkg::vc_mask_t                           i_output_free
);

  // Per channel view, indexed [channel][port]
  noc_pkg::port_mask_t [noc_pkg::CHANNELS-1:0] port_request;
  noc_pkg::port_mask_t [noc_pkg::CHANNELS-1:0] port_free;
  noc_pkg::port_mask_t [noc_pkg::CHANNELS-1:0] port_grant;
  noc_pkg::port_mask_t [noc_pkg::CHANNELS-1:0] push_mask;

  // Per port view, indexed [port][channel]
  noc_pkg::vc_mask_t [noc_pkg::PORTS-1:0] vc_request;
  noc_pkg::vc_mask_t [noc_pkg::PORTS-1:0] vc_free;
  noc_pkg::vc_mask_t [noc_pkg::PORTS-1:0] vc_grant;

  noc_pkg::vc_mask_t fifo_push;
  noc_pkg::vc_mask_t fifo_full;

  // Port arbitration works on head flits of each channel
  always_comb begin
    for (int v = 0; v < noc_pkg::CHANNELS; v++) begin
      for (int p = 0; p < noc_pkg::PORTS; p++) begin
        port_request[v][p] = i_start_of_packet[p][v];
        port_free[v][p] = i_end_of_packet[p][v];
      end
    end
  end

  for (genvar v = 0; v < noc_pkg::CHANNELS; v++) begin : g_port_arb
    round_robin_arbiter #(
      .REQUESTS (noc_pkg::PORTS)
    ) u_port_arbiter (
      .i_clk     (i_clk),
      .i_rst_n   (i_rst_n),
      .i_request (port_request[v]),
      .i_free    (port_free[v]),
      .o_grant   (port_grant[v])
    );
  end

  // A port may only pick among channels it already owns at the output
  always_comb begin
    for (int p = 0; p < noc_pkg::PORTS; p++) begin
      for (int v = 0; v < noc_pkg::CHANNELS; v++) begin
        vc_request[p][v] = port_grant[v][p] & i_request[p][v] & i_vc_ready[v];
        vc_free[p][v] = port_grant[v][p] & i_free[p][v];
      end
    end
  end

  for (genvar p = 0; p < noc_pkg::PORTS; p++) begin : g_vc_arb
    round_robin_arbiter #(
      .REQUESTS (noc_pkg::CHANNELS)
    ) u_vc_arbiter (
      .i_clk     (i_clk),
      .i_rst_n   (i_rst_n),
      .i_request (vc_request[p]),
      .i_free    (vc_free[p]),
      .o_grant   (vc_grant[p])
    );
  end

  // Full grant FIFO stalls the channel, arbiter state stays held
  always_comb begin
    for (int p = 0; p < noc_pkg::PORTS; p++) begin
      o_grant[p] = vc_grant[p] & ~fifo_full;
    end
  end

  // Completed packets queue their port mask for the switch
  always_comb begin
    for (int v = 0; v < noc_pkg::CHANNELS; v++) begin
      for (int p = 0; p < noc_pkg::PORTS; p++) begin
        push_mask[v][p] = vc_free[p][v];
      end
      fifo_push[v] = |push_mask[v];
    end
  end

  for (genvar v = 0; v < noc_pkg::CHANNELS; v++) begin : g_grant_fifo
    grant_fifo u_grant_fifo (
      .i_clk   (i_clk),
      .i_rst_n (i_rst_n),
      .i_push  (fifo_push[v]),
      .i_data  (push_mask[v]),
      .i_pop   (i_output_free[v]),
      .o_data  (o_output_grant[v]),
      .o_full  (fifo_full[v])
    );

    // Switch selects at most one input per channel
    a_output_onehot : assert property (
      @(posedge i_clk) disable iff (!i_rst_n)
      $onehot0(o_output_grant[v])
    );
  end

endmodule

`default_nettype wire

// ==== rtl/round_robin_arbiter.sv ====
`default_nettype none

module round_robin_arbiter #(
  parameter int REQUESTS = 2
) (
  input  var logic                i_clk,
  input  var logic                i_rst_n,
  input  var logic [REQUESTS-1:0] i_request,
  input  var logic [REQUESTS-1:0] i_free,
  output var logic [REQUESTS-1:0] o_grant
);

  typedef logic [$clog2(REQUESTS)-1:0] idx_t;

  logic held_q;
  idx_t held_idx_q;
  // Index where the next search begins
  idx_t ptr_q;
  logic search_found;
  idx_t search_idx;
  idx_t winner_idx;
  logic release_grant;

  // Rotating search starting at the priority pointer
  always_comb begin
    int idx;
    idx = 0;
    search_found = 1'b0;
    search_idx = '0;
    for (int i = 0; i < REQUESTS; i++) begin
      idx = (int'(ptr_q) + i) % REQUESTS;
      if (!search_found && i_request[idx]) begin
        search_found = 1'b1;
        search_idx = idx_t'(idx);
      end
    end
  end

  // A held grant masks the live search result
  always_comb begin
    o_grant = '0;
    winner_idx = held_q ? held_idx_q : search_idx;
    if (held_q) begin
      o_grant[held_idx_q] = 1'b1;
    end else if (search_found) begin
      o_grant[search_idx] = 1'b1;
    end
  end

  assign release_grant = |(o_grant & i_free);

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      held_q <= 1'b0;
      ptr_q <= '0;
    end else if (release_grant) begin
      held_q <= 1'b0;
      // Lowest priority goes to the requester just served
      if (winner_idx == idx_t'(REQUESTS - 1)) begin
        ptr_q <= '0;
      end else begin
        ptr_q <= winner_idx + 1'b1;
      end
    end else if (!held_q && search_found) begin
      held_q <= 1'b1;
    end
  end

  always_ff @(posedge i_clk) begin
    if (!held_q && search_found) begin
      held_idx_q <= search_idx;
    end
  end

  // Requesters only release what they were given
  a_free_granted : assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    (i_free & ~o_grant) == '0
  );

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, then scan the log for a failure report
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f port_controller_local.f \
  --top-module tb_port_controller_local -o sim_tb \
  && ./obj_dir/sim_tb > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "Build or simulation run did not complete"; exit 1; }
cat sim.log
grep -q "Something failed" sim.log && exit 1 || exit 0

// ==== tests/tb_tests.svh ====
`ifndef TB_TESTS_SVH
`define TB_TESTS_SVH

function automatic grant_vec_t grant_for(input int p, input int v);
  grant_vec_t g;
  g = '0;
  g[p][v] = 1'b1;
  return g;
endfunction

function automatic noc_pkg::port_mask_t port_bit(input int p);
  noc_pkg::port_mask_t m;
  m = '0;
  m[p] = 1'b1;
  return m;
endfunction

task automatic check_grants(input grant_vec_t expected, input string what);
  if (grant !== expected) begin
    error_count++;
    $display("FAILED at %0t: %s, grant %b expected %b", $time, what, grant, expected);
  end
endtask

task automatic check_output(input int v, input noc_pkg::port_mask_t expected, input string what);
  if (output_grant[v] !== expected) begin
    error_count++;
    $display("FAILED at %0t: %s, VC%0d output grant %b expected %b",
             $time, what, v, output_grant[v], expected);
  end
endtask

// Polls once per cycle, mid low phase
task automatic wait_for_grant(input int p, input int v);
  int cycles;
  cycles = 0;
  while (grant[p][v] !== 1'b1 && cycles < 20) begin
    @(negedge clk);
    #5;
    cycles++;
  end
  if (grant[p][v] !== 1'b1) begin
    timeout_count++;
    $display("Timed out after %0d cycles waiting for port %0d to be granted VC%0d",
             cycles, p, v);
  end
endtask

task automatic start_packet(input int p, input int v);
  @(negedge clk);
  start_of_packet[p][v] = 1'b1;
  request[p][v] = 1'b1;
  #5;
endtask

// Free pushes the mask, end of packet releases the port arbiter
task automatic finish_packet(input int p, input int v, input noc_pkg::port_mask_t head,
                             input int gap);
  @(negedge clk);
  request[p][v] = 1'b0;
  free[p][v] = 1'b1;
  @(negedge clk);
  free[p][v] = 1'b0;
  #5;
  check_output(v, head, "head one cycle after free");
  repeat (gap) @(negedge clk);
  @(negedge clk);
  start_of_packet[p][v] = 1'b0;
  end_of_packet[p][v] = 1'b1;
  @(negedge clk);
  end_of_packet[p][v] = 1'b0;
endtask

task automatic pop_outputs(input noc_pkg::vc_mask_t which);
  @(negedge clk);
  output_free = which;
  @(negedge clk);
  output_free = '0;
  #5;
endtask

task automatic single_packet_flow();
  int p;
  int gap;
  p = $urandom % noc_pkg::PORTS;
  gap = $urandom % 3;
  #5;
  check_grants('0, "grant after reset");
  check_output(0, '0, "VC0 head after reset");
  check_output(1, '0, "VC1 head after reset");
  start_packet(p, 0);
  check_grants(grant_for(p, 0), "single packet grant");
  finish_packet(p, 0, port_bit(p), gap);
  pop_outputs(2'b01);
  check_output(0, '0, "VC0 head after pop");
endtask

// Five ports compete on VC1, port 0 comes back for the sixth turn
task automatic port_rotation();
  int n;
  int expected;
  @(negedge clk);
  for (int p = 0; p < noc_pkg::PORTS; p++) begin
    start_of_packet[p][1] = 1'b1;
    request[p][1] = 1'b1;
  end
  #5;
  for (n = 0; n < 6; n++) begin
    expected = n % noc_pkg::PORTS;
    wait_for_grant(expected, 1);
    check_grants(grant_for(expected, 1), "rotation grant on VC1");
    finish_packet(expected, 1, port_bit(expected), $urandom % 3);
    if (n == 0) begin
      start_of_packet[0][1] = 1'b1;
      request[0][1] = 1'b1;
    end
    pop_outputs(2'b10);
    check_output(1, '0, "VC1 head after pop");
  end
endtask

task automatic vc_ready_gating();
  int q;
  int hold;
  q = $urandom % noc_pkg::PORTS;
  hold = 1 + $urandom % 3;
  @(negedge clk);
  vc_ready[0] = 1'b0;
  start_of_packet[q][0] = 1'b1;
  request[q][0] = 1'b1;
  #5;
  check_grants('0, "grant while VC0 not ready");
  repeat (hold) begin
    @(negedge clk);
    #5;
    check_grants('0, "grant while VC0 not ready");
  end
  @(negedge clk);
  vc_ready[0] = 1'b1;
  #5;
  check_grants(grant_for(q, 0), "grant in the cycle VC0 turns ready");
  finish_packet(q, 0, port_bit(q), 0);
  pop_outputs(2'b01);
  check_output(0, '0, "VC0 head after pop");
endtask

task automatic fifo_backpressure();
  int a;
  int b;
  int c;
  a = $urandom % noc_pkg::PORTS;
  b = (a + 1 + $urandom % 4) % noc_pkg::PORTS;
  c = (b + 1) % noc_pkg::PORTS;
  if (c == a) begin
    c = (c + 1) % noc_pkg::PORTS;
  end
  start_packet(a, 0);
  check_grants(grant_for(a, 0), "first grant on VC0");
  finish_packet(a, 0, port_bit(a), 0);
  start_packet(b, 0);
  check_grants(grant_for(b, 0), "second grant on VC0");
  // Head keeps the older mask
  finish_packet(b, 0, port_bit(a), 0);
  start_packet(c, 0);
  check_grants('0, "grant while VC0 FIFO is full");
  check_output(0, port_bit(a), "VC0 head while full");
  pop_outputs(2'b01);
  check_output(0, port_bit(b), "VC0 head after one pop");
  wait_for_grant(c, 0);
  check_grants(grant_for(c, 0), "third grant after pop");
  finish_packet(c, 0, port_bit(b), 0);
  pop_outputs(2'b01);
  check_output(0, port_bit(c), "VC0 head after second pop");
  pop_outputs(2'b01);
  check_output(0, '0, "VC0 head after draining");
endtask

task automatic independent_channels();
  @(negedge clk);
  start_of_packet[1][0] = 1'b1;
  request[1][0] = 1'b1;
  start_of_packet[3][1] = 1'b1;
  request[3][1] = 1'b1;
  #5;
  check_grants(grant_for(1, 0) | grant_for(3, 1), "grants on both channels");
  finish_packet(1, 0, port_bit(1), 0);
  finish_packet(3, 1, port_bit(3), 0);
  check_output(0, port_bit(1), "VC0 head with both channels busy");
  check_output(1, port_bit(3), "VC1 head with both channels busy");
  pop_outputs(2'b11);
  check_output(0, '0, "VC0 head after pop");
  check_output(1, '0, "VC1 head after pop");
endtask

`endif

// ==== tests/tb_port_controller_local.sv ====
`default_nettype none

module tb_port_controller_local;

  typedef noc_pkg::vc_mask_t [noc_pkg::PORTS-1:0] grant_vec_t;

  logic clk;
  logic rst_n;
  noc_pkg::vc_mask_t vc_ready;
  grant_vec_t start_of_packet;
  grant_vec_t end_of_packet;
  grant_vec_t request;
  grant_vec_t free;
  grant_vec_t grant;
  noc_pkg::port_mask_t [noc_pkg::CHANNELS-1:0] output_grant;
  noc_pkg::vc_mask_t output_free;

  int error_count;
  int timeout_count;

  port_controller_local dut_i (
    .i_clk             (clk),
    .i_rst_n           (rst_n),
    .i_vc_ready        (vc_ready),
    .i_start_of_packet (start_of_packet),
    .i_end_of_packet   (end_of_packet),
    .i_request         (request),
    .i_free            (free),
    .o_grant           (grant),
    .o_output_grant    (output_grant),
    .i_output_free     (output_free)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #20 clk = ~clk;
    end
  end

  `include "tb_tests.svh"

  initial begin
    error_count = 0;
    timeout_count = 0;
    void'($urandom(32'ha795_4b4f));
    rst_n = 1'b0;
    vc_ready = '1;
    start_of_packet = '0;
    end_of_packet = '0;
    request = '0;
    free = '0;
    output_free = '0;
    repeat (10) @(negedge clk);
    rst_n = 1'b1;

    single_packet_flow();
    port_rotation();
    vc_ready_gating();
    fifo_backpressure();
    independent_channels();

    repeat (2) @(negedge clk);
    $display("Errors: %0d, timeouts: %0d", error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
